/* cluster_periph_pkg.sv */
// Cluster peripheral package
// Sizes, bus types, address map and register index encodings shared by all blocks
package cluster_periph_pkg;

  localparam int NB_CORES      = 4;
  localparam int DATA_WIDTH    = 32;
  localparam int ADDR_WIDTH    = 32;
  localparam int ID_WIDTH      = NB_CORES + 1;
  localparam int ACC_EVT_WIDTH = 4;
  // Timer, DMA, four accelerator lines and two spare bits
  localparam int EVT_WIDTH     = 8;

  localparam logic [ADDR_WIDTH-1:0] BOOT_ADDR_RST = 32'h1C00_0000;
  localparam logic [DATA_WIDTH-1:0] ERR_RDATA     = 32'hDEAD_B33F;

  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [ID_WIDTH-1:0]      id_t;
  typedef logic [NB_CORES-1:0]      core_vec_t;
  typedef logic [ACC_EVT_WIDTH-1:0] acc_evt_t;
  typedef logic [EVT_WIDTH-1:0]     evt_vec_t;

  // Target select, address bits 11:10
  typedef enum logic [1:0] {
    TGT_CTRL  = 2'd0,
    TGT_TIMER = 2'd1,
    TGT_EVENT = 2'd2,
    TGT_NONE  = 2'd3
  } periph_target_e;

  // Control unit word index, address bits 5:2
  typedef enum logic [3:0] {
    CTRL_EOC      = 4'd0,
    CTRL_FETCH_EN = 4'd1,
    CTRL_BOOT0    = 4'd4,
    CTRL_BOOT1    = 4'd5,
    CTRL_BOOT2    = 4'd6,
    CTRL_BOOT3    = 4'd7
  } ctrl_reg_e;

  // Timer word index, address bits 5:2
  typedef enum logic [3:0] {
    TMR_CFG   = 4'd0,
    TMR_VALUE = 4'd1,
    TMR_CMP   = 4'd2
  } timer_reg_e;

  // Event unit word index, address bits 3:2 (core in bits 5:4)
  typedef enum logic [1:0] {
    EU_MASK   = 2'd0,
    EU_BUFFER = 2'd1,
    EU_CLEAR  = 2'd2
  } eu_reg_e;

endpackage

/* periph_bus_if.sv */
// Peripheral bus link
// Request/grant strobe with a one-cycle response pulse
`timescale 1ns/1ps

interface periph_bus_if;
  import cluster_periph_pkg::*;

  logic  req;
  addr_t add;
  // Low means write
  logic  wen;
  data_t wdata;
  id_t   id;
  logic  gnt;
  logic  r_valid;
  data_t r_rdata;
  // High flags an error response
  logic  r_opc;
  id_t   r_id;

  modport master (
    output req, add, wen, wdata, id,
    input  gnt, r_valid, r_rdata, r_opc, r_id
  );

  modport slave (
    input  req, add, wen, wdata, id,
    output gnt, r_valid, r_rdata, r_opc, r_id
  );

endinterface

/* periph_addr_decoder.sv */
// Peripheral address decoder
// Steers each request to one target and returns responses, errors for unmapped space
`timescale 1ns/1ps

module periph_addr_decoder (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_i,
  input  cluster_periph_pkg::addr_t add_i,
  input  logic                      wen_i,
  input  cluster_periph_pkg::data_t wdata_i,
  input  cluster_periph_pkg::id_t   id_i,
  output logic                      gnt_o,
  output logic                      r_valid_o,
  output cluster_periph_pkg::data_t r_rdata_o,
  output logic                      r_opc_o,
  output cluster_periph_pkg::id_t   r_id_o,
  periph_bus_if.master              ctrl_bus,
  periph_bus_if.master              timer_bus,
  periph_bus_if.master              event_bus
);
  import cluster_periph_pkg::*;

  periph_target_e tgt;
  periph_target_e resp_tgt_q;
  logic           err_valid_q;
  id_t            err_id_q;

  assign tgt = periph_target_e'(add_i[11:10]);

  // **************************************************
  // Request side
  // **************************************************
  assign ctrl_bus.req    = req_i & (tgt == TGT_CTRL);
  assign ctrl_bus.add    = add_i;
  assign ctrl_bus.wen    = wen_i;
  assign ctrl_bus.wdata  = wdata_i;
  assign ctrl_bus.id     = id_i;

  assign timer_bus.req   = req_i & (tgt == TGT_TIMER);
  assign timer_bus.add   = add_i;
  assign timer_bus.wen   = wen_i;
  assign timer_bus.wdata = wdata_i;
  assign timer_bus.id    = id_i;

  assign event_bus.req   = req_i & (tgt == TGT_EVENT);
  assign event_bus.add   = add_i;
  assign event_bus.wen   = wen_i;
  assign event_bus.wdata = wdata_i;
  assign event_bus.id    = id_i;

  // Unmapped space is always granted by the decoder itself
  always_comb begin
    case (tgt)
      TGT_CTRL:  gnt_o = ctrl_bus.gnt;
      TGT_TIMER: gnt_o = timer_bus.gnt;
      TGT_EVENT: gnt_o = event_bus.gnt;
      default:   gnt_o = req_i;
    endcase
  end

  // **************************************************
  // Response side
  // **************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_tgt_q  <= TGT_NONE;
      err_valid_q <= 1'b0;
    end else begin
      err_valid_q <= req_i & (tgt == TGT_NONE);
      if (req_i) begin
        resp_tgt_q <= tgt;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      err_id_q <= id_i;
    end
  end

  always_comb begin
    case (resp_tgt_q)
      TGT_CTRL: begin
        r_valid_o = ctrl_bus.r_valid;
        r_rdata_o = ctrl_bus.r_rdata;
        r_opc_o   = ctrl_bus.r_opc;
        r_id_o    = ctrl_bus.r_id;
      end
      TGT_TIMER: begin
        r_valid_o = timer_bus.r_valid;
        r_rdata_o = timer_bus.r_rdata;
        r_opc_o   = timer_bus.r_opc;
        r_id_o    = timer_bus.r_id;
      end
      TGT_EVENT: begin
        r_valid_o = event_bus.r_valid;
        r_rdata_o = event_bus.r_rdata;
        r_opc_o   = event_bus.r_opc;
        r_id_o    = event_bus.r_id;
      end
      default: begin
        r_valid_o = err_valid_q;
        r_rdata_o = ERR_RDATA;
        r_opc_o   = 1'b1;
        r_id_o    = err_id_q;
      end
    endcase
  end

endmodule

/* cluster_control_unit.sv */
// Cluster control unit
// End of computation flag, per-core fetch enable and boot addresses
`timescale 1ns/1ps

module cluster_control_unit (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  periph_bus_if.slave                   bus,
  output logic                          eoc_o,
  output cluster_periph_pkg::core_vec_t fetch_enable_o,
  output cluster_periph_pkg::addr_t     boot_addr_o [cluster_periph_pkg::NB_CORES]
);
  import cluster_periph_pkg::*;

  logic      eoc_q;
  core_vec_t fetch_en_q;
  addr_t     boot_addr_q [NB_CORES];
  ctrl_reg_e reg_idx;
  logic      wr_en;
  data_t     rd_data;
  logic      r_valid_q;
  data_t     r_rdata_q;
  id_t       r_id_q;

  assign reg_idx = ctrl_reg_e'(bus.add[5:2]);
  assign wr_en   = bus.req & ~bus.wen;

  // **************************************************
  // Register write
  // **************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q      <= 1'b0;
      fetch_en_q <= '0;
      for (int c = 0; c < NB_CORES; c++) begin
        boot_addr_q[c] <= BOOT_ADDR_RST;
      end
    end else if (wr_en) begin
      case (reg_idx)
        CTRL_EOC:      eoc_q      <= bus.wdata[0];
        CTRL_FETCH_EN: fetch_en_q <= bus.wdata[NB_CORES-1:0];
        // Boot words sit at consecutive indices, one per core
        CTRL_BOOT0, CTRL_BOOT1, CTRL_BOOT2, CTRL_BOOT3: begin
          boot_addr_q[bus.add[3:2]] <= bus.wdata;
        end
        default: ;
      endcase
    end
  end

  // Readback, unknown words return 0 without error
  always_comb begin
    case (reg_idx)
      CTRL_EOC:      rd_data = {{(DATA_WIDTH-1){1'b0}}, eoc_q};
      CTRL_FETCH_EN: rd_data = {{(DATA_WIDTH-NB_CORES){1'b0}}, fetch_en_q};
      CTRL_BOOT0, CTRL_BOOT1, CTRL_BOOT2, CTRL_BOOT3: begin
        rd_data = boot_addr_q[bus.add[3:2]];
      end
      default:       rd_data = '0;
    endcase
  end

  // **************************************************
  // Response
  // **************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      r_rdata_q <= rd_data;
      r_id_q    <= bus.id;
    end
  end

  assign bus.gnt     = bus.req;
  assign bus.r_valid = r_valid_q;
  assign bus.r_rdata = r_rdata_q;
  assign bus.r_opc   = 1'b0;
  assign bus.r_id    = r_id_q;

  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

/* cluster_timer.sv */
// Cluster timer
// 32-bit up counter with compare match interrupt and optional clear on match
`timescale 1ns/1ps

module cluster_timer (
  input  logic        clk_i,
  input  logic        rst_n_i,
  periph_bus_if.slave bus,
  output logic        irq_o,
  output logic        busy_o
);
  import cluster_periph_pkg::*;

  logic       cfg_en_q;
  logic       cfg_clr_q;
  data_t      value_q;
  data_t      cmp_q;
  logic       irq_q;
  logic       match;
  timer_reg_e reg_idx;
  logic       wr_en;
  data_t      rd_data;
  logic       r_valid_q;
  data_t      r_rdata_q;
  id_t        r_id_q;

  assign reg_idx = timer_reg_e'(bus.add[5:2]);
  assign wr_en   = bus.req & ~bus.wen;
  assign match   = cfg_en_q & (value_q == cmp_q);

  // **************************************************
  // Configuration and counter
  // **************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_en_q  <= 1'b0;
      cfg_clr_q <= 1'b0;
      cmp_q     <= '0;
      value_q   <= '0;
      irq_q     <= 1'b0;
    end else begin
      irq_q <= match;
      if (wr_en && reg_idx == TMR_CFG) begin
        cfg_en_q  <= bus.wdata[0];
        cfg_clr_q <= bus.wdata[1];
      end
      if (wr_en && reg_idx == TMR_CMP) begin
        cmp_q <= bus.wdata;
      end
      // A software load wins over counting
      if (wr_en && reg_idx == TMR_VALUE) begin
        value_q <= bus.wdata;
      end else if (match && cfg_clr_q) begin
        value_q <= '0;
      end else if (cfg_en_q) begin
        value_q <= value_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (reg_idx)
      TMR_CFG:   rd_data = {{(DATA_WIDTH-2){1'b0}}, cfg_clr_q, cfg_en_q};
      TMR_VALUE: rd_data = value_q;
      TMR_CMP:   rd_data = cmp_q;
      default:   rd_data = '0;
    endcase
  end

  // **************************************************
  // Response
  // **************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      r_rdata_q <= rd_data;
      r_id_q    <= bus.id;
    end
  end

  assign bus.gnt     = bus.req;
  assign bus.r_valid = r_valid_q;
  assign bus.r_rdata = r_rdata_q;
  assign bus.r_opc   = 1'b0;
  assign bus.r_id    = r_id_q;

  // irq is the registered match, so one cycle wide per hit
  assign irq_o  = irq_q;
  assign busy_o = cfg_en_q;

endmodule

/* cluster_event_unit.sv */
// Cluster event unit
// Sticky per-core event buffers under a mask, one level interrupt request per core
`timescale 1ns/1ps

module cluster_event_unit (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  periph_bus_if.slave                   bus,
  input  logic                          timer_evt_i,
  input  cluster_periph_pkg::core_vec_t dma_event_i,
  input  cluster_periph_pkg::acc_evt_t  acc_events_i [cluster_periph_pkg::NB_CORES],
  output cluster_periph_pkg::core_vec_t irq_req_o
);
  import cluster_periph_pkg::*;

  evt_vec_t   evt_in [NB_CORES];
  evt_vec_t   mask_q [NB_CORES];
  evt_vec_t   buf_q  [NB_CORES];
  eu_reg_e    reg_idx;
  logic [1:0] core_sel;
  logic       wr_en;
  data_t      rd_data;
  logic       r_valid_q;
  data_t      r_rdata_q;
  id_t        r_id_q;

  assign reg_idx  = eu_reg_e'(bus.add[3:2]);
  assign core_sel = bus.add[5:4];
  assign wr_en    = bus.req & ~bus.wen;

  // Event vector per core, timer line is shared, spare bits stay 0
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      evt_in[c] = {{(EVT_WIDTH-ACC_EVT_WIDTH-2){1'b0}},
                   acc_events_i[c], dma_event_i[c], timer_evt_i};
      irq_req_o[c] = |(buf_q[c] & mask_q[c]);
    end
  end

  // **************************************************
  // Masks and buffers
  // **************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int c = 0; c < NB_CORES; c++) begin
        mask_q[c] <= '0;
        buf_q[c]  <= '0;
      end
    end else begin
      for (int c = 0; c < NB_CORES; c++) begin
        if (wr_en && core_sel == c && reg_idx == EU_MASK) begin
          mask_q[c] <= bus.wdata[EVT_WIDTH-1:0];
        end
        // new events win over a clear in the same cycle
        if (wr_en && core_sel == c && reg_idx == EU_CLEAR) begin
          buf_q[c] <= (buf_q[c] & ~bus.wdata[EVT_WIDTH-1:0]) | evt_in[c];
        end else begin
          buf_q[c] <= buf_q[c] | evt_in[c];
        end
      end
    end
  end

  always_comb begin
    case (reg_idx)
      EU_MASK:   rd_data = {{(DATA_WIDTH-EVT_WIDTH){1'b0}}, mask_q[core_sel]};
      EU_BUFFER: rd_data = {{(DATA_WIDTH-EVT_WIDTH){1'b0}}, buf_q[core_sel]};
      default:   rd_data = '0;
    endcase
  end

  // **************************************************
  // Response
  // **************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      r_rdata_q <= rd_data;
      r_id_q    <= bus.id;
    end
  end

  assign bus.gnt     = bus.req;
  assign bus.r_valid = r_valid_q;
  assign bus.r_rdata = r_rdata_q;
  assign bus.r_opc   = 1'b0;
  assign bus.r_id    = r_id_q;

endmodule

/* cluster_peripherals.sv */
// Cluster peripherals top level
// Bus decoder feeding the control unit, timer and event unit
`timescale 1ns/1ps

module cluster_peripherals (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // Peripheral bus slave port
  input  logic                          periph_req_i,
  input  cluster_periph_pkg::addr_t     periph_add_i,
  input  logic                          periph_wen_i,
  input  cluster_periph_pkg::data_t     periph_wdata_i,
  input  cluster_periph_pkg::id_t       periph_id_i,
  output logic                          periph_gnt_o,
  output logic                          periph_r_valid_o,
  output cluster_periph_pkg::data_t     periph_r_rdata_o,
  output logic                          periph_r_opc_o,
  output cluster_periph_pkg::id_t       periph_r_id_o,

  // Event sources
  input  cluster_periph_pkg::core_vec_t dma_event_i,
  input  cluster_periph_pkg::acc_evt_t  acc_events_i [cluster_periph_pkg::NB_CORES],

  // Core control
  output logic                          eoc_o,
  output cluster_periph_pkg::core_vec_t fetch_enable_o,
  output cluster_periph_pkg::addr_t     boot_addr_o [cluster_periph_pkg::NB_CORES],
  output cluster_periph_pkg::core_vec_t irq_req_o,
  output logic                          busy_o
);

  logic timer_irq;

  periph_bus_if ctrl_bus ();
  periph_bus_if timer_bus ();
  periph_bus_if event_bus ();

  // **************************************************
  // Address decoder
  // **************************************************
  periph_addr_decoder u_decoder (
    .clk_i     ( clk_i            ),
    .rst_n_i   ( rst_n_i          ),
    .req_i     ( periph_req_i     ),
    .add_i     ( periph_add_i     ),
    .wen_i     ( periph_wen_i     ),
    .wdata_i   ( periph_wdata_i   ),
    .id_i      ( periph_id_i      ),
    .gnt_o     ( periph_gnt_o     ),
    .r_valid_o ( periph_r_valid_o ),
    .r_rdata_o ( periph_r_rdata_o ),
    .r_opc_o   ( periph_r_opc_o   ),
    .r_id_o    ( periph_r_id_o    ),
    .ctrl_bus  ( ctrl_bus         ),
    .timer_bus ( timer_bus        ),
    .event_bus ( event_bus        )
  );

  // **************************************************
  // Targets
  // **************************************************
  cluster_control_unit u_ctrl (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .bus            ( ctrl_bus       ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer u_timer (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .bus     ( timer_bus ),
    .irq_o   ( timer_irq ),
    .busy_o  ( busy_o    )
  );

  // Timer interrupt is an event for every core
  cluster_event_unit u_event (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .bus          ( event_bus    ),
    .timer_evt_i  ( timer_irq    ),
    .dma_event_i  ( dma_event_i  ),
    .acc_events_i ( acc_events_i ),
    .irq_req_o    ( irq_req_o    )
  );

endmodule

/* tb_cluster_peripherals.sv */
// Cluster peripherals testbench
// Replays bus operations and event stimulus from the data file and checks every response
`timescale 1ns/1ps

module tb_cluster_peripherals;
  import cluster_periph_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int MODE_NONE  = 0;
  localparam int MODE_EQ    = 1;
  localparam int MODE_LE    = 2;

  logic      clk;
  logic      rst_n;
  logic      req;
  addr_t     add;
  logic      wen;
  data_t     wdata;
  id_t       id;
  logic      gnt;
  logic      r_valid;
  data_t     r_rdata;
  logic      r_opc;
  id_t       r_id;
  core_vec_t dma_event;
  acc_evt_t  acc_events [NB_CORES];
  logic      eoc;
  core_vec_t fetch_enable;
  addr_t     boot_addr [NB_CORES];
  core_vec_t irq_req;
  logic      busy;

  // Operations parsed from the data file
  logic [7:0] op_q [$];
  int         ln_q [$];
  data_t      a_q [$];
  data_t      b_q [$];
  data_t      c_q [$];
  logic       parsed;
  int         limit_cycles;
  int         err_cnt;

  // Event stimulus for the next cycle
  core_vec_t nx_dma;
  acc_evt_t  nx_acc [NB_CORES];

  // Expected boot address of each core, follows the boot word writes
  addr_t boot_exp [NB_CORES];

  // Request still waiting for its response
  logic  p_valid;
  id_t   p_id;
  int    p_mode;
  data_t p_data;
  logic  p_opc;
  string p_name;

  logic [31:0] lfsr;

  cluster_peripherals u_dut (
    .clk_i            ( clk          ),
    .rst_n_i          ( rst_n        ),
    .periph_req_i     ( req          ),
    .periph_add_i     ( add          ),
    .periph_wen_i     ( wen          ),
    .periph_wdata_i   ( wdata        ),
    .periph_id_i      ( id           ),
    .periph_gnt_o     ( gnt          ),
    .periph_r_valid_o ( r_valid      ),
    .periph_r_rdata_o ( r_rdata      ),
    .periph_r_opc_o   ( r_opc        ),
    .periph_r_id_o    ( r_id         ),
    .dma_event_i      ( dma_event    ),
    .acc_events_i     ( acc_events   ),
    .eoc_o            ( eoc          ),
    .fetch_enable_o   ( fetch_enable ),
    .boot_addr_o      ( boot_addr    ),
    .irq_req_o        ( irq_req      ),
    .busy_o           ( busy         )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // **************************************************
  // Checks
  // **************************************************
  task automatic fail_run();
    err_cnt++;
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_id(input string name, input id_t exp, input id_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_core_vec(input string name, input core_vec_t exp, input core_vec_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      fail_run();
    end
  endtask

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic draw_bits(input int nbits, output data_t val);
    val = '0;
    for (int b = 0; b < nbits; b++) begin
      lfsr   = lfsr_next(lfsr);
      val[b] = lfsr[0];
    end
  endtask

  task automatic load_testdata();
    int         fd;
    int         cnt;
    int         ln;
    string      line;
    logic [7:0] op;
    data_t      a;
    data_t      b;
    data_t      c;
    fd           = $fopen("cluster_periph_testdata.txt", "r");
    ln           = 0;
    limit_cycles = 10;
    if (fd == 0) begin
      $display("Could not open the data file cluster_periph_testdata.txt");
      fail_run();
    end
    while (!$feof(fd)) begin
      cnt = $fgets(line, fd);
      ln++;
      if (cnt > 1 && line.getc(0) != "#") begin
        a   = '0;
        b   = '0;
        c   = '0;
        cnt = $sscanf(line, "%c %h %h %h", op, a, b, c);
        op_q.push_back(op);
        ln_q.push_back(ln);
        a_q.push_back(a);
        b_q.push_back(b);
        c_q.push_back(c);
        limit_cycles += 20;
        if (op == "N") begin
          limit_cycles += a;
        end
        if (op == "B") begin
          limit_cycles += 2 * a;
        end
      end
    end
    $fclose(fd);
  endtask

  // Drives one cycle of bus and event stimulus and checks gnt and the previous response
  task automatic run_cycle(input string name, input logic rq, input logic we, input addr_t a,
                           input data_t wd, input int mode, input data_t exp_data,
                           input logic exp_opc);
    data_t rnd;
    id_t   rid;
    rid = '0;
    if (rq) begin
      draw_bits(ID_WIDTH, rnd);
      rid = rnd[ID_WIDTH-1:0];
    end
    @(posedge clk);
    #10;
    req        = rq;
    add        = a;
    wen        = we;
    wdata      = wd;
    id         = rid;
    dma_event  = nx_dma;
    acc_events = nx_acc;
    #50;
    check_bit({name, " gnt"}, rq, gnt);
    if (p_valid) begin
      if (r_valid !== 1'b1) begin
        $display("No response arrived in the cycle after the request of %s", p_name);
        fail_run();
      end
      check_id({p_name, " r_id"}, p_id, r_id);
      check_bit({p_name, " r_opc"}, p_opc, r_opc);
      if (p_mode == MODE_EQ) begin
        check_data({p_name, " r_rdata"}, p_data, r_rdata);
      end else if (p_mode == MODE_LE) begin
        check_bit({p_name, " value within compare"}, 1'b1, r_rdata <= p_data);
      end
    end else begin
      check_bit({name, " r_valid"}, 1'b0, r_valid);
    end
    p_valid = rq;
    p_id    = rid;
    p_mode  = mode;
    p_data  = exp_data;
    p_opc   = exp_opc;
    p_name  = name;
  endtask

  // **************************************************
  // Watchdog
  // **************************************************
  initial begin
    wait (parsed);
    #(limit_cycles * CLK_PERIOD);
    $display("Timeout after %0d cycles, the test sequence did not complete", limit_cycles);
    fail_run();
  end

  // **************************************************
  // Main sequence
  // **************************************************
  initial begin
    string name;
    string pname;
    data_t rnd;
    addr_t baddr;
    logic  unmapped;
    rst_n     = 1'b0;
    req       = 1'b0;
    add       = '0;
    wen       = 1'b1;
    wdata     = '0;
    id        = '0;
    dma_event = '0;
    nx_dma    = '0;
    for (int c = 0; c < NB_CORES; c++) begin
      acc_events[c] = '0;
      nx_acc[c]     = '0;
      boot_exp[c]   = BOOT_ADDR_RST;
    end
    p_valid = 1'b0;
    p_id    = '0;
    p_mode  = MODE_NONE;
    p_data  = '0;
    p_opc   = 1'b0;
    p_name  = "";
    lfsr    = 32'h83a6_fde3;
    err_cnt = 0;
    parsed  = 1'b0;
    load_testdata();
    parsed = 1'b1;
    repeat (3) @(posedge clk);
    #10;
    rst_n = 1'b1;

    for (int i = 0; i < op_q.size(); i++) begin
      name = $sformatf("line %0d %c", ln_q[i], op_q[i]);
      case (op_q[i])
        "W": begin
          // Unmapped writes still answer with the error word
          unmapped = (a_q[i][11:10] == 2'd3);
          run_cycle(name, 1'b1, 1'b0, a_q[i], b_q[i],
                    unmapped ? MODE_EQ : MODE_NONE, ERR_RDATA, unmapped);
          // Boot words are control indices 4 to 7, core in address bits 3:2
          if (a_q[i][11:10] == 2'd0 && a_q[i][5:4] == 2'b01) begin
            boot_exp[a_q[i][3:2]] = b_q[i];
          end
        end
        "R": run_cycle(name, 1'b1, 1'b1, a_q[i], '0, MODE_EQ, b_q[i], c_q[i][0]);
        "T": run_cycle(name, 1'b1, 1'b1, a_q[i], '0, MODE_LE, b_q[i], 1'b0);
        "E": begin
          nx_dma = a_q[i][NB_CORES-1:0];
          for (int c = 0; c < NB_CORES; c++) begin
            nx_acc[c] = b_q[i][4*c +: 4];
          end
          run_cycle(name, 1'b0, 1'b1, '0, '0, MODE_NONE, '0, 1'b0);
          nx_dma = '0;
          for (int c = 0; c < NB_CORES; c++) begin
            nx_acc[c] = '0;
          end
        end
        "I": begin
          run_cycle(name, 1'b0, 1'b1, '0, '0, MODE_NONE, '0, 1'b0);
          check_core_vec({name, " irq_req"}, a_q[i][NB_CORES-1:0], irq_req);
        end
        "P": begin
          run_cycle(name, 1'b0, 1'b1, '0, '0, MODE_NONE, '0, 1'b0);
          check_bit({name, " eoc"}, a_q[i][0], eoc);
          check_core_vec({name, " fetch_enable"}, b_q[i][NB_CORES-1:0], fetch_enable);
          check_bit({name, " busy"}, c_q[i][0], busy);
          for (int c = 0; c < NB_CORES; c++) begin
            check_data($sformatf("%s boot_addr %0d", name, c), boot_exp[c], boot_addr[c]);
          end
        end
        "A": begin
          run_cycle(name, 1'b0, 1'b1, '0, '0, MODE_NONE, '0, 1'b0);
          check_data({name, " boot_addr"}, b_q[i], boot_addr[a_q[i][1:0]]);
        end
        "N": begin
          repeat (a_q[i]) run_cycle(name, 1'b0, 1'b1, '0, '0, MODE_NONE, '0, 1'b0);
        end
        "B": begin
          // Write then read back each boot word in back-to-back cycles
          for (int k = 0; k < a_q[i]; k++) begin
            draw_bits(DATA_WIDTH, rnd);
            baddr = 32'h10 + 4 * (k % NB_CORES);
            pname = $sformatf("%s pair %0d", name, k);
            run_cycle({pname, " write"}, 1'b1, 1'b0, baddr, rnd, MODE_NONE, '0, 1'b0);
            boot_exp[k % NB_CORES] = rnd;
            run_cycle({pname, " read"}, 1'b1, 1'b1, baddr, '0, MODE_EQ, rnd, 1'b0);
          end
        end
        default: begin
          $display("Unknown operation on line %0d of the data file", ln_q[i]);
          fail_run();
        end
      endcase
    end

    // Collect the last response
    run_cycle("final idle", 1'b0, 1'b1, '0, '0, MODE_NONE, '0, 1'b0);

    if (err_cnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      fail_run();
    end
  end

endmodule

/* cluster_periph_testdata.txt */
# Columns: op a b c, all values hex. W addr data | R addr data opc | T addr max | A core boot
# E dma acc(core3..core0 nibbles) | I irq | P eoc fetch busy | N cycles | B write/read pairs
A 0 1c000000
A 3 1c000000
P 0 0 0
I 0
W 00000000 00000001
W 00000004 0000000a
W 00000010 1c008000
W 00000014 1c008100
W 00000018 1c008200
W 0000001c 1c008300
R 00000004 0000000a 0
R 00000018 1c008200 0
R 00000000 00000001 0
P 1 a 0
A 1 1c008100
A 3 1c008300
R 00000c10 deadb33f 1
W 00000c04 12345678
W 00000408 00000010
W 00000400 00000003
P 1 a 1
N 28
R 00000804 00000001 0
R 00000834 00000001 0
T 00000404 00000010
W 00000400 00000000
P 1 a 0
W 00000800 00000002
W 00000810 00000004
W 00000820 00000020
W 00000830 00000002
E 5 4210
I 3
W 00000818 00000004
I 1
W 00000808 00000002
I 0
E 0 0800
I 4
B 8

/* all.f */
cluster_periph_pkg.sv
periph_bus_if.sv
periph_addr_decoder.sv
cluster_control_unit.sv
cluster_timer.sv
cluster_event_unit.sv
cluster_peripherals.sv
tb_cluster_peripherals.sv
